/* disp_fetch.sv */
`timescale 1ns/1ps

module disp_fetch (
	input logic clkSYS,
	input logic n_reset,
	input logic disp_en,
	input logic pix_req,
	output logic req,
	output memsys_pkg::mem_addr_t addr,
	output logic wr,
	output memsys_pkg::mem_data_t data,
	output memsys_pkg::mem_id_t id,
	input logic ack,
	input logic valid,
	input memsys_pkg::mem_data_t rdata,
	output memsys_pkg::mem_data_t pix,
	output logic pix_valid,
	output memsys_pkg::fifo_level_t fifo_level
);

memsys_pkg::mem_data_t fifo_mem [2 ** memsys_pkg::FIFO_DEPTH_BITS];
memsys_pkg::fifo_ptr_t wr_ptr;
memsys_pkg::fifo_ptr_t rd_ptr;
memsys_pkg::region_off_t offset;
memsys_pkg::beat_t beats;
logic busy;
logic stale;
logic room;
logic push;
logic pop;

assign addr = memsys_pkg::REGION_BASE + memsys_pkg::mem_addr_t'(offset);
assign wr = 1'b0;
assign data = '0;
assign id = memsys_pkg::ID_DISP;

assign room = fifo_level <= memsys_pkg::fifo_level_t'((2 ** memsys_pkg::FIFO_DEPTH_BITS) -
	memsys_pkg::BURST);
// Words of a burst started before disp_en dropped are thrown away
assign push = valid && busy && disp_en && ~stale;
assign pop = pix_req && disp_en && fifo_level != '0;

always_ff @(posedge clkSYS, negedge n_reset) begin
	if (~n_reset) begin
		req <= 1'b0;
		busy <= 1'b0;
		stale <= 1'b0;
		beats <= '0;
		offset <= '0;
	end else if (~busy) begin
		stale <= 1'b0;
		if (~disp_en) begin
			offset <= '0;
		end else if (room) begin
			req <= 1'b1;
			busy <= 1'b1;
			beats <= '0;
		end
	end else begin
		if (~disp_en)
			stale <= 1'b1;
		if (ack)
			req <= 1'b0;
		if (valid)
			beats <= beats + 1'b1;
		if (valid && beats == memsys_pkg::beat_t'(memsys_pkg::BURST - 1)) begin
			busy <= 1'b0;
			if (stale || ~disp_en)
				offset <= '0;
			else if (offset == memsys_pkg::region_off_t'(memsys_pkg::REGION_WORDS -
					memsys_pkg::BURST))
				offset <= '0;
			else
				offset <= offset + memsys_pkg::region_off_t'(memsys_pkg::BURST);
		end
	end
end

always_ff @(posedge clkSYS, negedge n_reset) begin
	if (~n_reset) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		fifo_level <= '0;
		pix_valid <= 1'b0;
	end else begin
		pix_valid <= pop;
		if (~disp_en) begin
			// Flush so the next enable starts clean at the base
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_level <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && ~pop)
				fifo_level <= fifo_level + 1'b1;
			else if (pop && ~push)
				fifo_level <= fifo_level - 1'b1;
		end
	end
end

always_ff @(posedge clkSYS) begin
	if (push)
		fifo_mem[wr_ptr] <= rdata;
	if (pop)
		pix <= fifo_mem[rd_ptr];
end

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
	input logic clkSYS,
	input logic n_reset,

	input logic disp_req,
	input memsys_pkg::mem_addr_t disp_addr,
	input memsys_pkg::mem_data_t disp_data,
	input logic disp_wr,
	input memsys_pkg::mem_id_t disp_id,
	output logic disp_ack,
	output logic disp_valid,

	input logic test_req,
	input memsys_pkg::mem_addr_t test_addr,
	input memsys_pkg::mem_data_t test_data,
	input logic test_wr,
	input memsys_pkg::mem_id_t test_id,
	output logic test_ack,
	output logic test_valid,

	output memsys_pkg::mem_data_t client_rdata,

	output logic mem_req,
	output memsys_pkg::mem_addr_t mem_addr,
	output memsys_pkg::mem_data_t mem_data,
	output logic mem_wr,
	output memsys_pkg::mem_id_t mem_id,
	input logic mem_ack,
	input memsys_pkg::mem_data_t rd_data,
	input memsys_pkg::mem_id_t rd_id,
	input logic rd_valid
);

logic ack_latch;
logic idle;
logic grant_disp;
logic grant_test;

// No grant while a request is out or right after its ack
assign idle = ~mem_req && ~ack_latch;
assign grant_disp = idle && disp_req;
assign grant_test = idle && ~disp_req && test_req;

always_ff @(posedge clkSYS, negedge n_reset) begin
	if (~n_reset) begin
		ack_latch <= 1'b0;
		mem_req <= 1'b0;
	end else begin
		ack_latch <= mem_ack;
		if (mem_ack || ack_latch)
			mem_req <= 1'b0;
		else if (grant_disp || grant_test)
			mem_req <= 1'b1;
	end
end

// Request fields, display first
always_ff @(posedge clkSYS) begin
	if (grant_disp) begin
		mem_addr <= disp_addr;
		mem_data <= disp_data;
		mem_wr <= disp_wr;
		mem_id <= disp_id;
	end else if (grant_test) begin
		mem_addr <= test_addr;
		mem_data <= test_data;
		mem_wr <= test_wr;
		mem_id <= test_id;
	end
end

// Return path routed by id
always_ff @(posedge clkSYS, negedge n_reset) begin
	if (~n_reset) begin
		disp_ack <= 1'b0;
		test_ack <= 1'b0;
		disp_valid <= 1'b0;
		test_valid <= 1'b0;
	end else begin
		disp_ack <= mem_ack && mem_id == disp_id;
		test_ack <= mem_ack && mem_id == test_id;
		disp_valid <= rd_valid && rd_id == disp_id;
		test_valid <= rd_valid && rd_id == test_id;
	end
end

always_ff @(posedge clkSYS)
	client_rdata <= rd_data;

endmodule

/* mem_backend.sv */
`timescale 1ns/1ps

module mem_backend (
	input logic clkSYS,
	input logic n_reset,
	input logic mem_req,
	input memsys_pkg::mem_addr_t mem_addr,
	input memsys_pkg::mem_data_t mem_data,
	input logic mem_wr,
	input memsys_pkg::mem_id_t mem_id,
	output logic mem_ack,
	output memsys_pkg::mem_data_t rd_data,
	output memsys_pkg::mem_id_t rd_id,
	output logic rd_valid
);

memsys_pkg::mem_data_t mem_array [2 ** memsys_pkg::MEM_DEPTH_BITS];

logic busy;
logic reading;
logic accept;
logic emit;
memsys_pkg::seq_cnt_t cnt;
memsys_pkg::mem_idx_t rd_ptr;

assign accept = ~busy && mem_req;

// Fetch one word ahead of each valid cycle
assign emit = reading
	&& cnt >= memsys_pkg::seq_cnt_t'(memsys_pkg::READ_LATENCY - 1)
	&& cnt < memsys_pkg::seq_cnt_t'(memsys_pkg::READ_LATENCY + memsys_pkg::BURST - 1);

always_ff @(posedge clkSYS, negedge n_reset) begin
	if (~n_reset) begin
		busy <= 1'b0;
		reading <= 1'b0;
		mem_ack <= 1'b0;
		rd_valid <= 1'b0;
		cnt <= '0;
	end else if (accept) begin
		busy <= 1'b1;
		reading <= ~mem_wr;
		mem_ack <= 1'b1;
		cnt <= '0;
	end else if (busy) begin
		mem_ack <= 1'b0;
		if (~reading) begin
			busy <= 1'b0;
		end else begin
			cnt <= cnt + 1'b1;
			if (cnt == memsys_pkg::seq_cnt_t'(memsys_pkg::READ_LATENCY +
					memsys_pkg::BURST - 1)) begin
				// Burst finished
				busy <= 1'b0;
				reading <= 1'b0;
				rd_valid <= 1'b0;
			end else if (cnt == memsys_pkg::seq_cnt_t'(memsys_pkg::READ_LATENCY - 1)) begin
				rd_valid <= 1'b1;
			end
		end
	end
end

always_ff @(posedge clkSYS) begin
	if (accept && mem_wr)
		mem_array[mem_addr[memsys_pkg::MEM_DEPTH_BITS - 1:0]] <= mem_data;
	if (accept) begin
		rd_ptr <= mem_addr[memsys_pkg::MEM_DEPTH_BITS - 1:0];
		rd_id <= mem_id;
	end else if (emit) begin
		rd_ptr <= rd_ptr + 1'b1;
	end
	if (emit)
		rd_data <= mem_array[rd_ptr];
end

endmodule

/* mem_pattern_test.sv */
`timescale 1ns/1ps

module mem_pattern_test (
	input logic clkSYS,
	input logic n_reset,
	input logic start,
	input memsys_pkg::mem_data_t pattern,
	output logic req,
	output memsys_pkg::mem_addr_t addr,
	output memsys_pkg::mem_data_t data,
	output logic wr,
	output memsys_pkg::mem_id_t id,
	input logic ack,
	input logic valid,
	input memsys_pkg::mem_data_t rdata,
	output logic done,
	output logic fail
);

memsys_pkg::test_state_t state;
memsys_pkg::region_off_t offset;
memsys_pkg::beat_t beats;
memsys_pkg::mem_data_t pat_q;
memsys_pkg::mem_addr_t word_addr;
memsys_pkg::mem_data_t expected;
logic can_start;

// Address of the word being written or compared
assign word_addr = memsys_pkg::REGION_BASE + memsys_pkg::mem_addr_t'(offset) +
	memsys_pkg::mem_addr_t'(beats);
assign expected = word_addr[15:0] ^ pat_q;

assign req = state == memsys_pkg::st_write || state == memsys_pkg::st_read_req;
assign wr = state == memsys_pkg::st_write;
assign addr = word_addr;
assign data = expected;
assign id = memsys_pkg::ID_TEST;
assign done = state == memsys_pkg::st_done;

assign can_start = start && (state == memsys_pkg::st_idle || state == memsys_pkg::st_done);

always_ff @(posedge clkSYS) begin
	if (can_start)
		pat_q <= pattern;
end

always_ff @(posedge clkSYS, negedge n_reset) begin
	if (~n_reset) begin
		state <= memsys_pkg::st_idle;
		offset <= '0;
		beats <= '0;
		fail <= 1'b0;
	end else if (can_start) begin
		state <= memsys_pkg::st_write;
		offset <= '0;
		beats <= '0;
		fail <= 1'b0;
	end else begin
		case (state)
			memsys_pkg::st_write: begin
				if (ack) begin
					if (offset == memsys_pkg::region_off_t'(memsys_pkg::REGION_WORDS - 1)) begin
						offset <= '0;
						state <= memsys_pkg::st_read_req;
					end else begin
						offset <= offset + 1'b1;
					end
				end
			end
			memsys_pkg::st_read_req: begin
				if (ack) begin
					beats <= '0;
					state <= memsys_pkg::st_read_wait;
				end
			end
			memsys_pkg::st_read_wait: begin
				if (valid) begin
					if (rdata != expected)
						fail <= 1'b1;
					beats <= beats + 1'b1;
					if (beats == memsys_pkg::beat_t'(memsys_pkg::BURST - 1)) begin
						// Last word of this burst
						if (offset == memsys_pkg::region_off_t'(memsys_pkg::REGION_WORDS -
								memsys_pkg::BURST)) begin
							state <= memsys_pkg::st_done;
						end else begin
							offset <= offset + memsys_pkg::region_off_t'(memsys_pkg::BURST);
							state <= memsys_pkg::st_read_req;
						end
					end
				end
			end
			memsys_pkg::st_done:
				state <= memsys_pkg::st_idle;
			default:
				state <= memsys_pkg::st_idle;
		endcase
	end
end

endmodule

/* memsys_cases.txt */
# name  pattern(hex)  mode(serial|concurrent)  pixels
# Pixel n of a case is (REGION_BASE + n mod 32) ^ pattern, low 16 bits
# A concurrent case needs an earlier case, its pixels may still hold the old pattern
serial_a     a5c3  serial      40
serial_b     3c0f  serial      72
conc_c       ffff  concurrent  48
serial_d     0000  serial      36
conc_e       1234  concurrent  64

/* memsys_pkg.sv */
package memsys_pkg;

	typedef logic [23:0] mem_addr_t;
	typedef logic [15:0] mem_data_t;
	typedef logic [1:0] mem_id_t;

	localparam int BURST = 8;
	localparam int MEM_DEPTH_BITS = 10;
	localparam mem_id_t ID_DISP = 2'd2;
	localparam mem_id_t ID_TEST = 2'd3;

	// Region shared by the display and the memory test
	localparam mem_addr_t REGION_BASE = 24'hfb0000;
	localparam int REGION_WORDS = 32;

	localparam int READ_LATENCY = 3;
	localparam int FIFO_DEPTH_BITS = 4;

	typedef logic [MEM_DEPTH_BITS - 1:0] mem_idx_t;
	typedef logic [FIFO_DEPTH_BITS - 1:0] fifo_ptr_t;
	typedef logic [FIFO_DEPTH_BITS:0] fifo_level_t;
	typedef logic [$clog2(BURST) - 1:0] beat_t;
	typedef logic [$clog2(REGION_WORDS) - 1:0] region_off_t;
	// Backend sequence counter, covers ack, latency and burst
	typedef logic [$clog2(READ_LATENCY + BURST) - 1:0] seq_cnt_t;

	typedef enum logic [2:0] {
		st_idle,
		st_write,
		st_read_req,
		st_read_wait,
		st_done
	} test_state_t;

endpackage

/* memsys_sva.sv */
`timescale 1ns/1ps

module memsys_sva (
	input logic clkSYS,
	input logic n_reset,
	input logic mem_req,
	input logic mem_ack,
	input logic rd_valid,
	input logic disp_ack,
	input logic test_ack
);

int fail_count = 0;
int run_len;

// Length of the current rd_valid run
always_ff @(posedge clkSYS, negedge n_reset) begin
	if (~n_reset)
		run_len <= 0;
	else if (rd_valid)
		run_len <= run_len + 1;
	else
		run_len <= 0;
end

req_held: assert property (@(posedge clkSYS) disable iff (~n_reset)
	mem_req && ~mem_ack |=> mem_req)
	else begin
		$error("mem_req dropped before mem_ack");
		fail_count++;
	end

ack_single: assert property (@(posedge clkSYS) disable iff (~n_reset)
	mem_ack |=> ~mem_ack)
	else begin
		$error("mem_ack high for more than one cycle");
		fail_count++;
	end

burst_not_long: assert property (@(posedge clkSYS) disable iff (~n_reset)
	rd_valid |-> run_len < memsys_pkg::BURST)
	else begin
		$error("rd_valid longer than a burst");
		fail_count++;
	end

burst_not_short: assert property (@(posedge clkSYS) disable iff (~n_reset)
	~rd_valid && run_len != 0 |-> run_len == memsys_pkg::BURST)
	else begin
		$error("rd_valid ended before a full burst");
		fail_count++;
	end

acks_exclusive: assert property (@(posedge clkSYS) disable iff (~n_reset)
	~(disp_ack && test_ack))
	else begin
		$error("display and test acks high together");
		fail_count++;
	end

endmodule

// Memory side rules in the backend, client ack rule in the arbiter
bind mem_backend memsys_sva sva_mem (
	.clkSYS(clkSYS), .n_reset(n_reset), .mem_req(mem_req), .mem_ack(mem_ack),
	.rd_valid(rd_valid), .disp_ack(1'b0), .test_ack(1'b0));

bind mem_arbiter memsys_sva sva_arb (
	.clkSYS(clkSYS), .n_reset(n_reset), .mem_req(1'b0), .mem_ack(1'b0),
	.rd_valid(1'b0), .disp_ack(disp_ack), .test_ack(test_ack));

/* memsys_tb.sv */
`timescale 1ns/1ps

module memsys_tb;

logic clkSYS;
logic n_reset;
logic test_start;
memsys_pkg::mem_data_t pattern;
logic disp_en;
logic pix_req;
memsys_pkg::mem_data_t pix;
logic pix_valid;
memsys_pkg::fifo_level_t fifo_level;
logic test_done;
logic test_fail;

string case_names[$];
memsys_pkg::mem_data_t case_pats[$];
logic case_conc[$];
int case_pixels[$];
string case_name;
int errors;
int tests_run;
int tests_failed;
int limit_cycles;
int unsigned lcg_state;

memsys_top dut (
	.clkSYS(clkSYS), .n_reset(n_reset), .test_start(test_start), .pattern(pattern),
	.disp_en(disp_en), .pix_req(pix_req), .pix(pix), .pix_valid(pix_valid),
	.fifo_level(fifo_level), .test_done(test_done), .test_fail(test_fail));

initial begin
	clkSYS = 1'b0;
	forever #10 clkSYS = ~clkSYS;
end

function automatic int next_gap();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return int'((lcg_state >> 16) % 4);
endfunction

// Expected word at position n of the display stream
function automatic memsys_pkg::mem_data_t pixel_value(input int n,
		input memsys_pkg::mem_data_t pat);
	memsys_pkg::mem_addr_t a;
	a = memsys_pkg::REGION_BASE + memsys_pkg::mem_addr_t'(n % memsys_pkg::REGION_WORDS);
	return a[15:0] ^ pat;
endfunction

task automatic load_cases();
	int fd;
	int n;
	int pixels;
	int unsigned pat;
	string line;
	string name;
	string mode;
	fd = $fopen("memsys_cases.txt", "r");
	if (fd == 0) begin
		$display("cannot open memsys_cases.txt");
		errors++;
	end else begin
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			n = 0;
			if (line.len() > 0 && line[0] != "#")
				n = $sscanf(line, "%s %h %s %d", name, pat, mode, pixels);
			if (n == 4 && (mode == "serial" || mode == "concurrent")) begin
				case_names.push_back(name);
				case_pats.push_back(memsys_pkg::mem_data_t'(pat));
				case_conc.push_back(mode == "concurrent");
				case_pixels.push_back(pixels);
			end else if (n > 0) begin
				$display("bad line in memsys_cases.txt: %s", line);
				errors++;
			end
		end
		$fclose(fd);
	end
	if (case_names.size() == 0) begin
		$display("no cases found in memsys_cases.txt");
		errors++;
	end
endtask

task automatic start_test(input memsys_pkg::mem_data_t pat);
	@(posedge clkSYS);
	#2;
	pattern = pat;
	test_start = 1'b1;
	@(posedge clkSYS);
	#2;
	test_start = 1'b0;
endtask

task automatic wait_test_done();
	do begin
		@(posedge clkSYS);
		#1;
	end while (test_done !== 1'b1);
endtask

// Random pix_req pulses; a concurrent case accepts old or new pattern
task automatic collect_pixels(input int count, input logic either,
		input memsys_pkg::mem_data_t pat, input memsys_pkg::mem_data_t old_pat);
	int got;
	int gap_left;
	memsys_pkg::mem_data_t exp;
	got = 0;
	gap_left = 0;
	while (got < count) begin
		@(posedge clkSYS);
		#2;
		if (pix_valid) begin
			exp = pixel_value(got, pat);
			assert (pix === exp || (either && pix === pixel_value(got, old_pat))) else begin
				$display("mismatch %s: pixel %0d expected %h actual %h",
					case_name, got, exp, pix);
				errors++;
			end
			got++;
		end
		if (gap_left == 0) begin
			pix_req = 1'b1;
			gap_left = next_gap();
		end else begin
			pix_req = 1'b0;
			gap_left--;
		end
	end
	pix_req = 1'b0;
endtask

task automatic check_no_fail();
	assert (test_fail === 1'b0) else begin
		$display("mismatch %s: test_fail expected 0 actual %b", case_name, test_fail);
		errors++;
	end
endtask

task automatic report_case(input int err_before);
	tests_run++;
	if (errors == err_before) begin
		$display("%s: ok", case_name);
	end else begin
		tests_failed++;
		$display("%s: %0d errors", case_name, errors - err_before);
	end
endtask

task automatic run_case(input int i, input memsys_pkg::mem_data_t old_pat);
	int err_before;
	err_before = errors;
	case_name = case_names[i];
	if (case_conc[i]) begin
		@(posedge clkSYS);
		#2;
		disp_en = 1'b1;
		start_test(case_pats[i]);
		fork
			wait_test_done();
			collect_pixels(case_pixels[i], 1'b1, case_pats[i], old_pat);
		join
		check_no_fail();
	end else begin
		start_test(case_pats[i]);
		wait_test_done();
		check_no_fail();
		@(posedge clkSYS);
		#2;
		disp_en = 1'b1;
		collect_pixels(case_pixels[i], 1'b0, case_pats[i], case_pats[i]);
	end
	@(posedge clkSYS);
	#2;
	disp_en = 1'b0;
	// Let an in-flight display burst drain
	repeat (40) @(posedge clkSYS);
	report_case(err_before);
endtask

// FIFO bound and pix_valid only after a pix_req
initial begin
	forever begin
		@(posedge clkSYS);
		#1;
		assert (fifo_level <= memsys_pkg::fifo_level_t'(16)) else begin
			$display("%s: fifo_level %0d above 16", case_name, fifo_level);
			errors++;
		end
		assert (!pix_valid || pix_req) else begin
			$display("%s: pix_valid without a pix_req the cycle before", case_name);
			errors++;
		end
	end
end

initial begin
	wait (limit_cycles != 0);
	repeat (limit_cycles) @(posedge clkSYS);
	$display("timeout: run did not finish within %0d cycles", limit_cycles);
	$display("sim failed");
	$finish;
end

initial begin
	int pix_total;
	int total_errors;
	n_reset = 1'b0;
	test_start = 1'b0;
	pattern = '0;
	disp_en = 1'b0;
	pix_req = 1'b0;
	errors = 0;
	tests_run = 0;
	tests_failed = 0;
	limit_cycles = 0;
	lcg_state = 97;
	case_name = "reset";
	load_cases();
	pix_total = 0;
	foreach (case_pixels[i])
		pix_total += case_pixels[i];
	limit_cycles = (pix_total + memsys_pkg::REGION_WORDS) * 400;

	repeat (3) @(posedge clkSYS);
	#2;
	n_reset = 1'b1;
	@(posedge clkSYS);
	#1;
	assert (pix_valid === 1'b0 && test_done === 1'b0 && test_fail === 1'b0) else begin
		$display("mismatch reset: pix_valid test_done test_fail expected 000 actual %b%b%b",
			pix_valid, test_done, test_fail);
		errors++;
	end
	report_case(0);

	foreach (case_names[i])
		run_case(i, i == 0 ? case_pats[0] : case_pats[i - 1]);

	total_errors = errors + dut.mem0.sva_mem.fail_count + dut.arb0.sva_arb.fail_count;
	$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
	if (total_errors == 0 && tests_failed == 0)
		$display("sim passed");
	else
		$display("sim failed");
	$finish;
end

endmodule

/* memsys_top.sv */
`timescale 1ns/1ps

module memsys_top (
	input logic clkSYS,
	input logic n_reset,
	input logic test_start,
	input memsys_pkg::mem_data_t pattern,
	input logic disp_en,
	input logic pix_req,
	output memsys_pkg::mem_data_t pix,
	output logic pix_valid,
	output memsys_pkg::fifo_level_t fifo_level,
	output logic test_done,
	output logic test_fail
);

// Client side of the arbiter
logic disp_req, disp_wr, disp_ack, disp_valid;
memsys_pkg::mem_addr_t disp_addr;
memsys_pkg::mem_data_t disp_data;
memsys_pkg::mem_id_t disp_id;
logic test_req, test_wr, test_ack, test_valid;
memsys_pkg::mem_addr_t test_addr;
memsys_pkg::mem_data_t test_data;
memsys_pkg::mem_id_t test_id;
memsys_pkg::mem_data_t client_rdata;

// Memory side
logic mem_req, mem_wr, mem_ack, rd_valid;
memsys_pkg::mem_addr_t mem_addr;
memsys_pkg::mem_data_t mem_data, rd_data;
memsys_pkg::mem_id_t mem_id, rd_id;

mem_pattern_test test0 (.clkSYS(clkSYS), .n_reset(n_reset),
	.start(test_start), .pattern(pattern),
	.req(test_req), .addr(test_addr), .data(test_data), .wr(test_wr), .id(test_id),
	.ack(test_ack), .valid(test_valid), .rdata(client_rdata),
	.done(test_done), .fail(test_fail));

disp_fetch disp0 (.clkSYS(clkSYS), .n_reset(n_reset),
	.disp_en(disp_en), .pix_req(pix_req),
	.req(disp_req), .addr(disp_addr), .wr(disp_wr), .data(disp_data), .id(disp_id),
	.ack(disp_ack), .valid(disp_valid), .rdata(client_rdata),
	.pix(pix), .pix_valid(pix_valid), .fifo_level(fifo_level));

mem_arbiter arb0 (.clkSYS(clkSYS), .n_reset(n_reset),
	.disp_req(disp_req), .disp_addr(disp_addr), .disp_data(disp_data),
	.disp_wr(disp_wr), .disp_id(disp_id), .disp_ack(disp_ack), .disp_valid(disp_valid),
	.test_req(test_req), .test_addr(test_addr), .test_data(test_data),
	.test_wr(test_wr), .test_id(test_id), .test_ack(test_ack), .test_valid(test_valid),
	.client_rdata(client_rdata),
	.mem_req(mem_req), .mem_addr(mem_addr), .mem_data(mem_data), .mem_wr(mem_wr),
	.mem_id(mem_id), .mem_ack(mem_ack), .rd_data(rd_data), .rd_id(rd_id),
	.rd_valid(rd_valid));

mem_backend mem0 (.clkSYS(clkSYS), .n_reset(n_reset),
	.mem_req(mem_req), .mem_addr(mem_addr), .mem_data(mem_data), .mem_wr(mem_wr),
	.mem_id(mem_id), .mem_ack(mem_ack), .rd_data(rd_data), .rd_id(rd_id),
	.rd_valid(rd_valid));

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module memsys_tb -f verilog.f
./obj_dir/Vmemsys_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -qx "sim passed" sim.log; then
	echo "result: pass"
else
	echo "result: fail"
	exit 1
fi

/* verilog.f */
memsys_pkg.sv
mem_arbiter.sv
mem_backend.sv
disp_fetch.sv
mem_pattern_test.sv
memsys_top.sv
memsys_sva.sv
memsys_tb.sv
